// ==== hw/rem_config.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// signed remainder unit configuration
// operand width and the widths and stage count derived from it
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef REM_CONFIG_SVH
`define REM_CONFIG_SVH

// width of dividend, divisor and remainder at the ports
`define REM_WORD_WIDTH 8

// one extra bit so the most negative dividend has a positive counterpart
`define REM_LONG_WIDTH (`REM_WORD_WIDTH + 1)

// one division step per bit of the long word
// the first step only shifts, the divisor is not fully in the increment yet
`define REM_STEP_COUNT `REM_LONG_WIDTH

`endif

// ==== hw/rem_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// signed remainder types
// step opcode and the structs passed between pipeline stages
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "rem_config.svh"

package rem_pkg;

    // direction a step moves the remainder, always toward zero
    typedef enum logic {
        OP_ADD = 1'b0,
        OP_SUB = 1'b1
    } rem_op_e;

    // operands as seen on the input handshake
    typedef struct packed {
        logic [`REM_WORD_WIDTH-1:0] dividend;
        logic [`REM_WORD_WIDTH-1:0] divisor;
    } rem_request_t;

    // state of one item as it moves down the step chain
    typedef struct packed {
        logic                       valid;
        // running remainder, starts as the dividend
        logic [`REM_LONG_WIDTH-1:0] remainder;
        // divisor bits shifted in from the top
        logic [`REM_LONG_WIDTH-1:0] increment;
        // divisor bits still waiting, kept sign-extended
        logic [`REM_LONG_WIDTH-1:0] divisor_rest;
        // signs of the operands as loaded
        logic                       dividend_sign;
        logic                       divisor_sign;
        logic                       divide_by_zero;
    } rem_step_t;

    // what the output handshake carries
    typedef struct packed {
        logic [`REM_WORD_WIDTH-1:0] remainder;
        logic                       divide_by_zero;
    } rem_result_t;

endpackage

// ==== hw/rem_operand_loader.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// signed remainder operand loader
// first pipeline stage, widens the operands and builds the initial step state
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

`include "rem_config.svh"

module rem_operand_loader import rem_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  logic         advance,

    input  logic         input_valid,
    input  rem_request_t request,

    output rem_step_t    step_out
);

    // operands widened by one sign bit
    logic [`REM_LONG_WIDTH-1:0] dividend_long;
    logic [`REM_LONG_WIDTH-1:0] divisor_long;

    rem_step_t step_next;

    always_comb begin
        // sign extension into the long word
        dividend_long = {request.dividend[`REM_WORD_WIDTH-1], request.dividend};
        divisor_long  = {request.divisor[`REM_WORD_WIDTH-1], request.divisor};

        // a bubble still flows down the chain, only the valid bit tells
        step_next.valid = input_valid;

        // the dividend is the remainder before any step has run
        step_next.remainder = dividend_long;

        // the first shift happens here already
        // lowest divisor bit goes to the top of the increment
        step_next.increment = {divisor_long[0], {`REM_WORD_WIDTH{1'b0}}};

        // arithmetic shift right by one, done by hand
        step_next.divisor_rest = {divisor_long[`REM_LONG_WIDTH-1],
                                  divisor_long[`REM_LONG_WIDTH-1:1]};

        // initial signs pick add or subtract in every later step
        step_next.dividend_sign = dividend_long[`REM_LONG_WIDTH-1];
        step_next.divisor_sign  = divisor_long[`REM_LONG_WIDTH-1];

        // zero divisor leaves the dividend as the remainder
        step_next.divide_by_zero = (divisor_long == {`REM_LONG_WIDTH{1'b0}});
    end

    // payload loads on advance, only the valid bit is cleared by reset
    always_ff @(posedge clock) begin
        if (advance) begin
            step_out <= step_next;
        end
        if (reset) begin
            step_out.valid <= 1'b0;
        end
    end

endmodule

// ==== hw/rem_division_step.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// signed remainder division step
// one registered step of truncating long division, moving the remainder
// toward zero by the current increment when that does not overshoot
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

`include "rem_config.svh"

module rem_division_step import rem_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      advance,

    input  rem_step_t step_in,
    output rem_step_t step_out
);

    // add or subtract for this step
    rem_op_e op;

    // remainder if the increment were applied
    logic [`REM_LONG_WIDTH-1:0] candidate;
    logic                       candidate_overflow;

    // the individual acceptance tests
    logic increment_ok;
    logic rest_all_sign;
    logic candidate_ok;
    logic apply;

    rem_step_t step_next;

    always_comb begin
        // same signs means subtract to head toward zero, else add
        op = (step_in.dividend_sign == step_in.divisor_sign) ? OP_SUB : OP_ADD;

        // signed overflow from the operand and result sign bits
        if (op == OP_SUB) begin
            candidate = step_in.remainder - step_in.increment;
            candidate_overflow =
                (step_in.remainder[`REM_LONG_WIDTH-1] != step_in.increment[`REM_LONG_WIDTH-1])
                && (candidate[`REM_LONG_WIDTH-1] != step_in.remainder[`REM_LONG_WIDTH-1]);
        end else begin
            candidate = step_in.remainder + step_in.increment;
            candidate_overflow =
                (step_in.remainder[`REM_LONG_WIDTH-1] == step_in.increment[`REM_LONG_WIDTH-1])
                && (candidate[`REM_LONG_WIDTH-1] != step_in.remainder[`REM_LONG_WIDTH-1]);
        end

        // the increment only means something once its sign matches the divisor
        increment_ok = (step_in.increment[`REM_LONG_WIDTH-1] == step_in.divisor_sign);

        // and once nothing but sign bits are left in the divisor
        if (step_in.divisor_sign) begin
            rest_all_sign = (step_in.divisor_rest == {`REM_LONG_WIDTH{1'b1}});
        end else begin
            rest_all_sign = (step_in.divisor_rest == {`REM_LONG_WIDTH{1'b0}});
        end

        // no overshoot past zero, landing on zero is fine
        candidate_ok =
            ((candidate[`REM_LONG_WIDTH-1] == step_in.dividend_sign) && !candidate_overflow)
            || (candidate == {`REM_LONG_WIDTH{1'b0}});

        apply = increment_ok && rest_all_sign && candidate_ok && !step_in.divide_by_zero;

        // signs, flag and valid pass through untouched
        step_next = step_in;
        if (apply) begin
            step_next.remainder = candidate;
        end

        // next divisor bit enters the increment from the top
        step_next.increment = {step_in.divisor_rest[0],
                               step_in.increment[`REM_LONG_WIDTH-1:1]};

        // rest keeps its sign while it drains
        step_next.divisor_rest = {step_in.divisor_rest[`REM_LONG_WIDTH-1],
                                  step_in.divisor_rest[`REM_LONG_WIDTH-1:1]};
    end

    // whole stage holds while the output side is stalled
    always_ff @(posedge clock) begin
        if (advance) begin
            step_out <= step_next;
        end
        if (reset) begin
            step_out.valid <= 1'b0;
        end
    end

endmodule

// ==== hw/rem_result_stage.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// signed remainder result stage
// narrows the finished remainder and holds the output handshake
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

`include "rem_config.svh"

module rem_result_stage import rem_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  logic        advance,

    input  rem_step_t   step_in,

    output logic        output_valid,
    output rem_result_t result
);

    rem_result_t result_next;

    always_comb begin
        // the remainder is never larger in magnitude than the dividend
        // so the extra top bit is only a copy of the sign here
        result_next.remainder      = step_in.remainder[`REM_WORD_WIDTH-1:0];
        result_next.divide_by_zero = step_in.divide_by_zero;
    end

    // advance low means a result is waiting and output_ready is low,
    // so valid and data both stay put until the transfer
    always_ff @(posedge clock) begin
        if (advance) begin
            output_valid <= step_in.valid;
            result       <= result_next;
        end
        if (reset) begin
            output_valid <= 1'b0;
        end
    end

endmodule

// ==== hw/remainder_signed.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// signed integer remainder, fully unrolled pipeline
// remainder truncates toward zero and takes the sign of the dividend
// ready/valid on both sides, one new request per cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

`include "rem_config.svh"

module remainder_signed import rem_pkg::*; (
    input  logic         clock,
    input  logic         reset,

    // request side
    input  logic         input_valid,
    output logic         input_ready,
    input  rem_request_t request,

    // result side
    output logic         output_valid,
    input  logic         output_ready,
    output rem_result_t  result
);

    // whole pipeline moves together or not at all
    logic advance;

    // entry 0 from the loader, entry k+1 from step k
    rem_step_t step_chain [0:`REM_STEP_COUNT];

    // the only back-pressure point, result stage empty or being read
    always_comb begin
        advance     = !output_valid || output_ready;
        input_ready = advance;
    end

    rem_operand_loader i_loader (
        .clock       (clock),
        .reset       (reset),
        .advance     (advance),
        .input_valid (input_valid),
        .request     (request),
        .step_out    (step_chain[0])
    );

    // one stage per bit of the long word
    genvar k;
    generate
        for (k = 0; k < `REM_STEP_COUNT; k++) begin : g_step
            rem_division_step i_step (
                .clock    (clock),
                .reset    (reset),
                .advance  (advance),
                .step_in  (step_chain[k]),
                .step_out (step_chain[k+1])
            );
        end
    endgenerate

    // last step feeds the output register
    rem_result_stage i_result (
        .clock        (clock),
        .reset        (reset),
        .advance      (advance),
        .step_in      (step_chain[`REM_STEP_COUNT]),
        .output_valid (output_valid),
        .result       (result)
    );

endmodule

// ==== testbench/tb_clock_gen.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench clock and reset
// 4 ns clock, synchronous reset held high over the first two rising edges
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module tb_clock_gen (
    output logic clock,
    output logic reset
);

    localparam int half_period_ns = 2;

    initial begin
        clock = 1'b0;
        forever #(half_period_ns) clock = ~clock;
    end

    // released just after the second edge, same offset as the stimulus
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clock);
        #1;
        reset = 1'b0;
    end

endmodule

// ==== testbench/tb_remainder_signed.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the pipelined signed remainder unit
// directed table, then random vectors under output back-pressure,
// results checked in order against a truncating remainder model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

`include "rem_config.svh"

module tb_remainder_signed import rem_pkg::*; ();

    localparam int word_width      = `REM_WORD_WIDTH;
    localparam int table_count     = 15;
    localparam int random_count    = 200;
    localparam int vector_count    = table_count + random_count;
    localparam int clock_period_ns = 4;
    localparam int watchdog_ns     =
        (vector_count + `REM_STEP_COUNT + 2) * 4 * clock_period_ns;

    localparam logic [31:0] lcg_seed = 32'd14854;

    // most negative and most positive word
    localparam logic [word_width-1:0] word_min = {1'b1, {(word_width-1){1'b0}}};
    localparam logic [word_width-1:0] word_max = {1'b0, {(word_width-1){1'b1}}};

    typedef struct packed {
        logic [word_width-1:0] dividend;
        logic [word_width-1:0] divisor;
        logic [word_width-1:0] remainder;
        logic                  divide_by_zero;
    } table_entry_t;

    logic         clock;
    logic         reset;
    logic         input_valid;
    logic         input_ready;
    rem_request_t request;
    logic         output_valid;
    logic         output_ready;
    rem_result_t  result;

    table_entry_t case_table [table_count];
    rem_request_t vec_request [vector_count];
    rem_result_t  vec_expected [vector_count];

    // expected results of accepted requests, oldest first
    rem_result_t  expected_queue [$];
    int           received;
    logic         random_phase;
    logic [31:0]  ready_state;

    tb_clock_gen i_clock_gen (
        .clock (clock),
        .reset (reset)
    );

    remainder_signed i_remainder_signed (
        .clock        (clock),
        .reset        (reset),
        .input_valid  (input_valid),
        .input_ready  (input_ready),
        .request      (request),
        .output_valid (output_valid),
        .output_ready (output_ready),
        .result       (result)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [word_width-1:0] to_word(input int value);
        return word_width'(value);
    endfunction

    // C style remainder, sign follows the dividend, zero divisor passes it through
    function automatic rem_result_t model_remainder(input logic [word_width-1:0] dividend,
                                                    input logic [word_width-1:0] divisor);
        rem_result_t expected;
        longint      a;
        longint      b;
        a = longint'($signed(dividend));
        b = longint'($signed(divisor));
        if (divisor == '0) begin
            expected.remainder      = dividend;
            expected.divide_by_zero = 1'b1;
        end else begin
            expected.remainder      = word_width'(a % b);
            expected.divide_by_zero = 1'b0;
        end
        return expected;
    endfunction

    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string signal_name, input int got, input int expected);
        report_failure($sformatf("Mismatch at %0t: %s got %0d expected %0d",
                                 $time, signal_name, got, expected));
    endtask

    // one output transfer, compared with the oldest outstanding request
    task automatic check_result();
        rem_result_t expected;
        if (expected_queue.size() == 0) begin
            report_failure("a result came out with no request outstanding");
        end else begin
            expected = expected_queue.pop_front();
            assert (result.remainder == expected.remainder)
            else report_mismatch("result.remainder", int'($signed(result.remainder)),
                                 int'($signed(expected.remainder)));
            assert (result.divide_by_zero == expected.divide_by_zero)
            else report_mismatch("result.divide_by_zero", int'(result.divide_by_zero),
                                 int'(expected.divide_by_zero));
            received++;
        end
    endtask

    initial begin
        #(watchdog_ns);
        report_failure($sformatf("timeout, only %0d of %0d results arrived",
                                 received, vector_count));
    end

    // outputs are sampled at the falling edge, inputs settled at +1 ns
    initial begin
        forever begin
            @(negedge clock);
            if (!reset && output_valid && output_ready) begin
                check_result();
            end
        end
    end

    // sink always ready in the table phase, random afterwards
    initial begin
        output_ready = 1'b1;
        ready_state  = lcg_seed;
        forever begin
            @(posedge clock);
            #1;
            if (random_phase) begin
                ready_state  = lcg_next(ready_state);
                output_ready = ready_state[20];
            end else begin
                output_ready = 1'b1;
            end
        end
    end

    initial begin
        logic [31:0] vector_state;
        logic        accepted;
        input_valid  = 1'b0;
        request      = '0;
        received     = 0;
        random_phase = 1'b0;

        case_table = '{
            '{to_word(22),  to_word(7),   to_word(1),   1'b0},
            '{to_word(-22), to_word(7),   to_word(-1),  1'b0},
            '{to_word(22),  to_word(-7),  to_word(1),   1'b0},
            '{to_word(-22), to_word(-7),  to_word(-1),  1'b0},
            '{to_word(7),   to_word(22),  to_word(7),   1'b0},
            '{to_word(-7),  to_word(-22), to_word(-7),  1'b0},
            '{to_word(-7),  to_word(22),  to_word(-7),  1'b0},
            '{to_word(7),   to_word(-22), to_word(7),   1'b0},
            '{to_word(0),   to_word(0),   to_word(0),   1'b1},
            '{to_word(22),  to_word(0),   to_word(22),  1'b1},
            '{to_word(-22), to_word(0),   to_word(-22), 1'b1},
            '{word_min,     to_word(-1),  to_word(0),   1'b0},
            '{word_min,     to_word(1),   to_word(0),   1'b0},
            '{word_min,     word_min,     to_word(0),   1'b0},
            '{word_max,     word_min,     word_max,     1'b0}
        };

        for (int i = 0; i < table_count; i++) begin
            vec_request[i].dividend             = case_table[i].dividend;
            vec_request[i].divisor              = case_table[i].divisor;
            vec_expected[i].remainder           = case_table[i].remainder;
            vec_expected[i].divide_by_zero      = case_table[i].divide_by_zero;
        end

        // random operands, roughly one divisor in sixteen forced to zero
        vector_state = lcg_seed;
        for (int i = table_count; i < vector_count; i++) begin
            vector_state = lcg_next(vector_state);
            vec_request[i].dividend = vector_state[16 +: word_width];
            vector_state = lcg_next(vector_state);
            vec_request[i].divisor = vector_state[16 +: word_width];
            if (vector_state[27:24] == 4'd0) begin
                vec_request[i].divisor = '0;
            end
            vec_expected[i] = model_remainder(vec_request[i].dividend, vec_request[i].divisor);
        end

        @(negedge reset);
        @(negedge clock);
        assert (output_valid == 1'b0)
        else report_mismatch("output_valid", int'(output_valid), 0);
        assert (input_ready == 1'b1)
        else report_mismatch("input_ready", int'(input_ready), 1);

        @(posedge clock);
        #1;
        for (int i = 0; i < vector_count; i++) begin
            request     = vec_request[i];
            input_valid = 1'b1;
            accepted    = 1'b0;
            // hold the request until an edge sees input_ready high
            while (!accepted) begin
                @(negedge clock);
                accepted = input_ready;
                if (accepted) begin
                    expected_queue.push_back(vec_expected[i]);
                    if (i + 1 >= table_count) begin
                        random_phase = 1'b1;
                    end
                end
                @(posedge clock);
                #1;
            end
        end
        input_valid = 1'b0;

        wait (received == vector_count);
        // a few more cycles so a duplicated result would still show up
        repeat (`REM_STEP_COUNT + 4) @(posedge clock);
        @(negedge clock);

        // every request is answered, so the result stage must be empty
        if (!output_valid) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            report_failure("an extra result is still waiting after the last expected one");
        end
    end

endmodule

// ==== remainder_signed.f ====
+incdir+hw
hw/rem_pkg.sv
hw/rem_operand_loader.sv
hw/rem_division_step.sv
hw/rem_result_stage.sv
hw/remainder_signed.sv
testbench/tb_clock_gen.sv
testbench/tb_remainder_signed.sv

// ==== Makefile ====
# Verilator build and run of the signed remainder testbench

SIM       := verilator
SIM_FLAGS := --binary --timing --assert -j 0 --timescale 1ns/10ps
TOP       := tb_remainder_signed
FILE_LIST := remainder_signed.f
BUILD_DIR := obj_dir
LOG_FILE  := sim.log
PASS_TEXT := Simulation completed successfully

# sources from the file list plus the included config header
SOURCES := $(shell grep -v '^+' $(FILE_LIST)) $(wildcard hw/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

# the log decides pass or fail, the pipe status alone is not enough
run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG_FILE)
	@grep -q "$(PASS_TEXT)" $(LOG_FILE) || (echo "run failed, see $(LOG_FILE)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG_FILE)
